// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = filelist.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+rtl
rtl/rv32i_types.sv
rtl/circular_queue.sv
rtl/fetch_decode.sv
rtl/rename_dispatch.sv
rtl/phys_reg_file.sv
rtl/reservation.sv
rtl/fu_alu.sv
rtl/rob.sv
rtl/cpu.sv
sim/cpu_tb.sv

// File: rtl/circular_queue.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module circular_queue #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4,
    parameter bit INIT_FULL = 1'b0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] in_data,
    input  logic             pop,
    output logic [WIDTH-1:0] out_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= INIT_FULL ? (PTR_W + 1)'(DEPTH) : '0;
            // Free list mode, spare tags follow the architectural ones
            if (INIT_FULL) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= WIDTH'(`ARCH_REGS + i);
                end
            end
        end else begin
            if (push) begin
                mem[tail] <= in_data;
                tail      <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    assign out_data = mem[head];
    assign full     = (count == (PTR_W + 1)'(DEPTH));
    assign empty    = (count == '0);

    // Producers and consumers must respect the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu (
    input  logic                clk,
    input  logic                rst,
    output logic                imem_read,
    output logic [31:0]         imem_addr,
    input  logic [31:0]         imem_rdata,
    input  logic                imem_resp,
    output logic                commit_valid,
    output logic [31:0]         commit_pc,
    output rv32i_types::areg_t  commit_rd,
    output logic [31:0]         commit_data
);

    import rv32i_types::*;

    // Queued record is pc, op, rd, rs1, rs2, use_imm, imm, writes_rd
    localparam int IQ_W = 32 + $bits(alu_op_t) + 3 * $bits(areg_t) + 1 + 32 + 1;

    logic            dec_valid, dec_use_imm, dec_writes_rd;
    logic [31:0]     dec_pc, dec_imm;
    alu_op_t         dec_op;
    areg_t           dec_rd, dec_rs1, dec_rs2;
    logic [IQ_W-1:0] iq_out;
    logic            iq_full, iq_empty, iq_pop;
    logic [31:0]     iq_pc, iq_imm;
    logic [3:0]      iq_op_bits;
    alu_op_t         iq_op;
    areg_t           iq_rd, iq_rs1, iq_rs2;
    logic            iq_use_imm, iq_writes_rd;
    logic            fl_empty, fl_pop;
    preg_t           fl_preg;
    logic            disp_en;
    preg_t           disp_preg, disp_old_preg, disp_ps1, disp_ps2;
    logic            rob_full, rs_full;
    rob_id_t         alloc_id;
    logic [`PHYS_REGS-1:0] ready_bits;
    preg_t           tag_a, tag_b, iss_preg;
    logic [31:0]     rd_data_a, rd_data_b, iss_imm;
    logic            iss_valid, iss_use_imm, iss_writes;
    alu_op_t         iss_op;
    rob_id_t         iss_rob_id;
    logic            cdb_valid, cdb_writes;
    preg_t           cdb_preg;
    rob_id_t         cdb_rob_id;
    logic [31:0]     cdb_data;
    logic            commit_writes;
    preg_t           commit_old_preg;

    fetch_decode fetch (
        .clk(clk), .rst(rst),
        .imem_read(imem_read), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp), .iq_full(iq_full),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_op(dec_op),
        .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_writes_rd(dec_writes_rd)
    );

    circular_queue #(.WIDTH(IQ_W), .DEPTH(`IQ_DEPTH), .INIT_FULL(1'b0)) instruction_queue (
        .clk(clk), .rst(rst),
        .push(dec_valid),
        .in_data({dec_pc, dec_op, dec_rd, dec_rs1, dec_rs2, dec_use_imm, dec_imm,
                  dec_writes_rd}),
        .pop(iq_pop), .out_data(iq_out), .full(iq_full), .empty(iq_empty)
    );

    assign {iq_pc, iq_op_bits, iq_rd, iq_rs1, iq_rs2, iq_use_imm, iq_imm, iq_writes_rd} = iq_out;
    assign iq_op = alu_op_t'(iq_op_bits);

    // Holds the spare tags, committed old tags come back here
    circular_queue #(.WIDTH(`PREG_W), .DEPTH(`FREE_DEPTH), .INIT_FULL(1'b1)) free_list (
        .clk(clk), .rst(rst),
        .push(commit_valid && commit_writes), .in_data(commit_old_preg),
        .pop(fl_pop), .out_data(fl_preg), .full(), .empty(fl_empty)
    );

    rename_dispatch rename (
        .clk(clk), .rst(rst),
        .iq_empty(iq_empty), .iq_rd(iq_rd), .iq_rs1(iq_rs1), .iq_rs2(iq_rs2),
        .iq_writes_rd(iq_writes_rd), .iq_pop(iq_pop),
        .fl_empty(fl_empty), .fl_preg(fl_preg), .fl_pop(fl_pop),
        .rob_full(rob_full), .rs_full(rs_full),
        .disp_en(disp_en), .disp_preg(disp_preg), .disp_old_preg(disp_old_preg),
        .disp_ps1(disp_ps1), .disp_ps2(disp_ps2),
        .commit_writes(commit_valid && commit_writes)
    );

    phys_reg_file prf (
        .clk(clk), .rst(rst),
        .disp_en(disp_en), .disp_preg(disp_preg),
        .cdb_valid(cdb_valid), .cdb_writes(cdb_writes), .cdb_preg(cdb_preg),
        .cdb_data(cdb_data),
        .rd_tag_a(tag_a), .rd_tag_b(tag_b), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .ready_bits(ready_bits)
    );

    reservation rs (
        .clk(clk), .rst(rst),
        .disp_en(disp_en), .disp_op(iq_op), .disp_ps1(disp_ps1), .disp_ps2(disp_ps2),
        .disp_use_imm(iq_use_imm), .disp_imm(iq_imm), .disp_preg(disp_preg),
        .disp_writes(iq_writes_rd), .alloc_id(alloc_id), .ready_bits(ready_bits),
        .cdb_valid(cdb_valid), .cdb_writes(cdb_writes), .cdb_preg(cdb_preg),
        .rs_full(rs_full),
        .iss_valid(iss_valid), .iss_op(iss_op), .tag_a(tag_a), .tag_b(tag_b),
        .iss_use_imm(iss_use_imm), .iss_imm(iss_imm), .iss_preg(iss_preg),
        .iss_rob_id(iss_rob_id), .iss_writes(iss_writes)
    );

    fu_alu alu (
        .clk(clk), .rst(rst),
        .iss_valid(iss_valid), .iss_op(iss_op), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .iss_use_imm(iss_use_imm), .iss_imm(iss_imm), .iss_preg(iss_preg),
        .iss_rob_id(iss_rob_id), .iss_writes(iss_writes),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .cdb_rob_id(cdb_rob_id),
        .cdb_data(cdb_data), .cdb_writes(cdb_writes)
    );

    rob reorder (
        .clk(clk), .rst(rst),
        .disp_en(disp_en), .disp_pc(iq_pc), .disp_rd(iq_rd),
        .disp_old_preg(disp_old_preg), .disp_writes(iq_writes_rd),
        .alloc_id(alloc_id), .rob_full(rob_full),
        .cdb_valid(cdb_valid), .cdb_rob_id(cdb_rob_id), .cdb_data(cdb_data),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_writes(commit_writes),
        .commit_old_preg(commit_old_preg)
    );

endmodule

// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Architectural and physical register counts
`define ARCH_REGS 32
`define PHYS_REGS 64
`define PREG_W 6

// Instruction queue entries
`define IQ_DEPTH 4

// Reorder buffer size and pointer width
`define ROB_DEPTH 8
`define ROB_W 3

// Reservation station entries and free list size
`define RS_DEPTH 4
`define FREE_DEPTH 32

`endif

// File: rtl/fetch_decode.sv
`timescale 1ns/1ns

module fetch_decode (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  imem_read,
    output logic [31:0]           imem_addr,
    input  logic [31:0]           imem_rdata,
    input  logic                  imem_resp,
    input  logic                  iq_full,
    output logic                  dec_valid,
    output logic [31:0]           dec_pc,
    output rv32i_types::alu_op_t  dec_op,
    output rv32i_types::areg_t    dec_rd,
    output rv32i_types::areg_t    dec_rs1,
    output rv32i_types::areg_t    dec_rs2,
    output logic                  dec_use_imm,
    output logic [31:0]           dec_imm,
    output logic                  dec_writes_rd
);

    import rv32i_types::*;

    fetch_state_t state;
    logic [31:0]  pc;
    opcode_t      opcode;
    logic [2:0]   funct3;
    logic         alt;
    logic         supported;

    // One request in flight, a new one only with room in the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: if (!iq_full) state <= WAIT_RESP;
                WAIT_RESP: begin
                    if (imem_resp) begin
                        pc    <= pc + 32'd4;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign imem_read = (state == WAIT_RESP);
    assign imem_addr = pc;

    assign opcode = opcode_t'(imem_rdata[6:0]);
    assign funct3 = imem_rdata[14:12];
    // Bit 30 picks SUB and SRA
    assign alt    = imem_rdata[30];

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
        supported   = 1'b1;
        case (opcode)
            OP, OP_IMM: begin
                dec_use_imm = (opcode == OP_IMM);
                case (funct3)
                    3'b000: dec_op = (alt && opcode == OP) ? ALU_SUB : ALU_ADD;
                    3'b001: dec_op = ALU_SLL;
                    3'b010: dec_op = ALU_SLT;
                    3'b011: dec_op = ALU_SLTU;
                    3'b100: dec_op = ALU_XOR;
                    3'b101: dec_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110: dec_op = ALU_OR;
                    default: dec_op = ALU_AND;
                endcase
            end
            LUI: begin
                dec_op      = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_imm     = {imem_rdata[31:12], 12'b0};
            end
            // Unknown encodings become a NOP
            default: supported = 1'b0;
        endcase
    end

    assign dec_valid     = imem_resp && (state == WAIT_RESP);
    assign dec_pc        = pc;
    assign dec_rd        = imem_rdata[11:7];
    // Immediate bits in source fields would only cause false dependencies
    assign dec_rs1       = (opcode == LUI) ? '0 : imem_rdata[19:15];
    assign dec_rs2       = dec_use_imm ? '0 : imem_rdata[24:20];
    assign dec_writes_rd = supported && (dec_rd != '0);

endmodule

// File: rtl/fu_alu.sv
`timescale 1ns/1ns

module fu_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  iss_valid,
    input  rv32i_types::alu_op_t  iss_op,
    input  logic [31:0]           rd_data_a,
    input  logic [31:0]           rd_data_b,
    input  logic                  iss_use_imm,
    input  logic [31:0]           iss_imm,
    input  rv32i_types::preg_t    iss_preg,
    input  rv32i_types::rob_id_t  iss_rob_id,
    input  logic                  iss_writes,
    output logic                  cdb_valid,
    output rv32i_types::preg_t    cdb_preg,
    output rv32i_types::rob_id_t  cdb_rob_id,
    output logic [31:0]           cdb_data,
    output logic                  cdb_writes
);

    import rv32i_types::*;

    logic [31:0] b;
    logic [31:0] result;

    assign b = iss_use_imm ? iss_imm : rd_data_b;

    always_comb begin
        case (iss_op)
            ALU_SUB:    result = rd_data_a - b;
            ALU_AND:    result = rd_data_a & b;
            ALU_OR:     result = rd_data_a | b;
            ALU_XOR:    result = rd_data_a ^ b;
            ALU_SLT:    result = {31'b0, $signed(rd_data_a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, rd_data_a < b};
            // Shift amount is the low five bits
            ALU_SLL:    result = rd_data_a << b[4:0];
            ALU_SRL:    result = rd_data_a >> b[4:0];
            ALU_SRA:    result = $unsigned($signed(rd_data_a) >>> b[4:0]);
            ALU_PASS_B: result = b;
            default:    result = rd_data_a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= iss_valid;
        end
    end

    // Bus payload, qualified by cdb_valid
    always_ff @(posedge clk) begin
        cdb_preg   <= iss_preg;
        cdb_rob_id <= iss_rob_id;
        cdb_data   <= result;
        cdb_writes <= iss_writes;
    end

endmodule

// File: rtl/phys_reg_file.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module phys_reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_en,
    input  rv32i_types::preg_t      disp_preg,
    input  logic                    cdb_valid,
    input  logic                    cdb_writes,
    input  rv32i_types::preg_t      cdb_preg,
    input  logic [31:0]             cdb_data,
    input  rv32i_types::preg_t      rd_tag_a,
    input  rv32i_types::preg_t      rd_tag_b,
    output logic [31:0]             rd_data_a,
    output logic [31:0]             rd_data_b,
    output logic [`PHYS_REGS-1:0]   ready_bits
);

    logic [31:0] regs [`PHYS_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_bits <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // New tag waits for its producer, p0 is always ready
            if (disp_en && disp_preg != '0) begin
                ready_bits[disp_preg] <= 1'b0;
            end
            if (cdb_valid && cdb_writes) begin
                regs[cdb_preg]       <= cdb_data;
                ready_bits[cdb_preg] <= 1'b1;
            end
        end
    end

    assign rd_data_a = regs[rd_tag_a];
    assign rd_data_b = regs[rd_tag_b];

    // x0 results never reach the file
    a_p0_const: assert property (@(posedge clk) disable iff (rst)
        (cdb_valid && cdb_writes) |-> cdb_preg != '0);

endmodule

// File: rtl/rename_dispatch.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module rename_dispatch (
    input  logic                clk,
    input  logic                rst,
    input  logic                iq_empty,
    input  rv32i_types::areg_t  iq_rd,
    input  rv32i_types::areg_t  iq_rs1,
    input  rv32i_types::areg_t  iq_rs2,
    input  logic                iq_writes_rd,
    output logic                iq_pop,
    input  logic                fl_empty,
    input  rv32i_types::preg_t  fl_preg,
    output logic                fl_pop,
    input  logic                rob_full,
    input  logic                rs_full,
    output logic                disp_en,
    output rv32i_types::preg_t  disp_preg,
    output rv32i_types::preg_t  disp_old_preg,
    output rv32i_types::preg_t  disp_ps1,
    output rv32i_types::preg_t  disp_ps2,
    input  logic                commit_writes
);

    import rv32i_types::*;

    localparam int LIVE_W = $clog2(`FREE_DEPTH + 1);

    preg_t             rat [`ARCH_REGS];
    logic [LIVE_W-1:0] live_tags;

    // Stall on any full structure, or no tag for a writer
    assign disp_en = !iq_empty && !rob_full && !rs_full && (!iq_writes_rd || !fl_empty);
    assign iq_pop  = disp_en;
    assign fl_pop  = disp_en && iq_writes_rd;

    // Lookup uses the mapping before this instruction renames rd
    assign disp_ps1      = rat[iq_rs1];
    assign disp_ps2      = rat[iq_rs2];
    assign disp_old_preg = rat[iq_rd];
    // p0 marks no destination
    assign disp_preg     = iq_writes_rd ? fl_preg : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= preg_t'(i);
            end
        end else if (fl_pop) begin
            // rd is never x0 here so p0 stays bound to x0
            rat[iq_rd] <= fl_preg;
        end
    end

    // Spare tags currently held by in-flight writers
    always_ff @(posedge clk) begin
        if (rst) begin
            live_tags <= '0;
        end else begin
            live_tags <= live_tags + LIVE_W'(fl_pop) - LIVE_W'(commit_writes);
        end
    end

    // Each spare tag in use belongs to an uncommitted ROB entry
    a_tag_balance: assert property (@(posedge clk) disable iff (rst)
        live_tags <= LIVE_W'(`ROB_DEPTH));

endmodule

// File: rtl/reservation.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module reservation (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_en,
    input  rv32i_types::alu_op_t    disp_op,
    input  rv32i_types::preg_t      disp_ps1,
    input  rv32i_types::preg_t      disp_ps2,
    input  logic                    disp_use_imm,
    input  logic [31:0]             disp_imm,
    input  rv32i_types::preg_t      disp_preg,
    input  logic                    disp_writes,
    input  rv32i_types::rob_id_t    alloc_id,
    input  logic [`PHYS_REGS-1:0]   ready_bits,
    input  logic                    cdb_valid,
    input  logic                    cdb_writes,
    input  rv32i_types::preg_t      cdb_preg,
    output logic                    rs_full,
    output logic                    iss_valid,
    output rv32i_types::alu_op_t    iss_op,
    output rv32i_types::preg_t      tag_a,
    output rv32i_types::preg_t      tag_b,
    output logic                    iss_use_imm,
    output logic [31:0]             iss_imm,
    output rv32i_types::preg_t      iss_preg,
    output rv32i_types::rob_id_t    iss_rob_id,
    output logic                    iss_writes
);

    import rv32i_types::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] valid;
    logic [`RS_DEPTH-1:0] rdy1;
    logic [`RS_DEPTH-1:0] rdy2;
    alu_op_t              op       [`RS_DEPTH];
    preg_t                ps1      [`RS_DEPTH];
    preg_t                ps2      [`RS_DEPTH];
    logic                 use_imm  [`RS_DEPTH];
    logic [31:0]          imm      [`RS_DEPTH];
    preg_t                dst      [`RS_DEPTH];
    rob_id_t              rob_id   [`RS_DEPTH];
    logic                 writes   [`RS_DEPTH];
    logic [IDX_W-1:0]     iss_idx;
    logic [IDX_W-1:0]     free_idx;

    // Source is ready in the file or arrives on the bus this cycle
    function automatic logic src_ready(preg_t tag);
        return ready_bits[tag] || (cdb_valid && cdb_writes && cdb_preg == tag);
    endfunction

    // Lowest index wins for both issue and insert
    always_comb begin
        iss_valid = 1'b0;
        iss_idx   = '0;
        free_idx  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                iss_valid = 1'b1;
                iss_idx   = IDX_W'(i);
            end
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            // Wakeup of waiting sources
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (cdb_valid && cdb_writes && ps1[i] == cdb_preg) rdy1[i] <= 1'b1;
                if (cdb_valid && cdb_writes && ps2[i] == cdb_preg) rdy2[i] <= 1'b1;
            end
            if (iss_valid) begin
                valid[iss_idx] <= 1'b0;
            end
            if (disp_en) begin
                valid[free_idx]   <= 1'b1;
                rdy1[free_idx]    <= src_ready(disp_ps1);
                rdy2[free_idx]    <= src_ready(disp_ps2);
                op[free_idx]      <= disp_op;
                ps1[free_idx]     <= disp_ps1;
                ps2[free_idx]     <= disp_ps2;
                use_imm[free_idx] <= disp_use_imm;
                imm[free_idx]     <= disp_imm;
                dst[free_idx]     <= disp_preg;
                rob_id[free_idx]  <= alloc_id;
                writes[free_idx]  <= disp_writes;
            end
        end
    end

    assign rs_full     = &valid;
    // Source tags go straight to the register file read ports
    assign tag_a       = ps1[iss_idx];
    assign tag_b       = ps2[iss_idx];
    assign iss_op      = op[iss_idx];
    assign iss_use_imm = use_imm[iss_idx];
    assign iss_imm     = imm[iss_idx];
    assign iss_preg    = dst[iss_idx];
    assign iss_rob_id  = rob_id[iss_idx];
    assign iss_writes  = writes[iss_idx];

endmodule

// File: rtl/rob.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module rob (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_en,
    input  logic [31:0]           disp_pc,
    input  rv32i_types::areg_t    disp_rd,
    input  rv32i_types::preg_t    disp_old_preg,
    input  logic                  disp_writes,
    output rv32i_types::rob_id_t  alloc_id,
    output logic                  rob_full,
    input  logic                  cdb_valid,
    input  rv32i_types::rob_id_t  cdb_rob_id,
    input  logic [31:0]           cdb_data,
    output logic                  commit_valid,
    output logic [31:0]           commit_pc,
    output rv32i_types::areg_t    commit_rd,
    output logic [31:0]           commit_data,
    output logic                  commit_writes,
    output rv32i_types::preg_t    commit_old_preg
);

    import rv32i_types::*;

    logic [`ROB_DEPTH-1:0] done;
    logic [31:0]           pc       [`ROB_DEPTH];
    areg_t                 rd       [`ROB_DEPTH];
    preg_t                 old_preg [`ROB_DEPTH];
    logic                  writes   [`ROB_DEPTH];
    logic [31:0]           data     [`ROB_DEPTH];
    logic [`ROB_W-1:0]     head;
    logic [`ROB_W-1:0]     tail;
    logic [`ROB_W:0]       count;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (disp_en) begin
                done[tail]     <= 1'b0;
                pc[tail]       <= disp_pc;
                rd[tail]       <= disp_rd;
                old_preg[tail] <= disp_old_preg;
                writes[tail]   <= disp_writes;
                tail           <= tail + 1'b1;
            end
            // Completion from the result bus
            if (cdb_valid) begin
                done[cdb_rob_id] <= 1'b1;
                data[cdb_rob_id] <= cdb_data;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (`ROB_W + 1)'(disp_en) - (`ROB_W + 1)'(commit_valid);
        end
    end

    assign alloc_id = tail;
    assign rob_full = (count == (`ROB_W + 1)'(`ROB_DEPTH));

    // In-order retirement, one per cycle
    assign commit_valid    = (count != '0) && done[head];
    assign commit_pc       = pc[head];
    assign commit_rd       = rd[head];
    assign commit_writes   = writes[head];
    // Non-writers and x0 report zero
    assign commit_data     = writes[head] ? data[head] : '0;
    assign commit_old_preg = old_preg[head];

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst) disp_en |-> !rob_full);

endmodule

// File: rtl/rv32i_types.sv
package rv32i_types;

    // RV32I major opcodes the core understands
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_t;

    // ALU operations, PASS_B forwards operand b for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    // Instruction fetch FSM
    typedef enum logic {
        IDLE,
        WAIT_RESP
    } fetch_state_t;

    // Register tags
    typedef logic [5:0] preg_t;
    typedef logic [2:0] rob_id_t;
    typedef logic [4:0] areg_t;

endpackage

// File: sim/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    import rv32i_types::*;

    localparam int NUM_INSTR = 200;
    // Worst case per instruction plus reset and pipeline drain
    localparam int MAX_CYCLES = NUM_INSTR * 20 + 100;

    logic        clk;
    logic        rst;
    logic        imem_read;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        commit_valid;
    logic [31:0] commit_pc;
    areg_t       commit_rd;
    logic [31:0] commit_data;

    logic [31:0] prog_mem  [NUM_INSTR];
    // Architectural state of the reference model
    logic [31:0] arch_regs [32];
    int          cycles;
    int          committed;
    bit          mem_pending;
    int          wait_left;
    // Next sequential fetch address
    logic [31:0] fetch_addr;

    cpu uut (
        .clk(clk),
        .rst(rst),
        .imem_read(imem_read),
        .imem_addr(imem_addr),
        .imem_rdata(imem_rdata),
        .imem_resp(imem_resp),
        .commit_valid(commit_valid),
        .commit_pc(commit_pc),
        .commit_rd(commit_rd),
        .commit_data(commit_data)
    );

    // Random supported instruction using x0 to x7 only
    function automatic logic [31:0] make_instr();
        alu_op_t     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        int          kind;
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        op   = alu_op_t'($urandom_range(0, 9));
        kind = int'($urandom_range(0, 9));
        alt  = 1'b0;
        // funct3 and funct7 bit 30 from the RV32I encoding tables
        case (op)
            ALU_SUB: begin
                f3  = 3'b000;
                alt = 1'b1;
            end
            ALU_SLL:  f3 = 3'b001;
            ALU_SLT:  f3 = 3'b010;
            ALU_SLTU: f3 = 3'b011;
            ALU_XOR:  f3 = 3'b100;
            ALU_SRL:  f3 = 3'b101;
            ALU_SRA: begin
                f3  = 3'b101;
                alt = 1'b1;
            end
            ALU_OR:   f3 = 3'b110;
            ALU_AND:  f3 = 3'b111;
            default:  f3 = 3'b000;
        endcase
        if (kind == 0) begin
            return {20'($urandom), rd, 7'b0110111};
        end
        if (kind <= 4) begin
            // No SUBI, so alt is dropped for funct3 000
            imm = 12'($urandom);
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b0, 5'($urandom)};
            end
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // Past the program end the memory returns addi x0, x0, 0
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < NUM_INSTR) begin
            return prog_mem[idx];
        end
        return 32'h0000_0013;
    endfunction

    // Executes one instruction on the architectural model
    function automatic void ref_step(input logic [31:0] instr, output logic [4:0] rd,
                                     output logic [31:0] value);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        opc = instr[6:0];
        f3  = instr[14:12];
        rd  = instr[11:7];
        a   = arch_regs[instr[19:15]];
        // I-type immediate, shamt sits in its low five bits
        if (opc == 7'b0010011) begin
            b = {{20{instr[31]}}, instr[31:20]};
        end else begin
            b = arch_regs[instr[24:20]];
        end
        case (f3)
            3'b000:  value = (opc == 7'b0110011 && instr[30]) ? a - b : a + b;
            3'b001:  value = a << b[4:0];
            3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  value = (a < b) ? 32'd1 : 32'd0;
            3'b100:  value = a ^ b;
            3'b101:  value = instr[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  value = a | b;
            default: value = a & b;
        endcase
        if (opc == 7'b0110111) begin
            value = {instr[31:12], 12'b0};
        end
        // x0 reads as zero forever
        if (rd == 5'd0) begin
            value = '0;
        end else begin
            arch_regs[rd] = value;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        void'($urandom(71));
        rst        = 1'b1;
        imem_rdata = '0;
        imem_resp  = 1'b0;
        committed  = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            prog_mem[i] = make_instr();
        end
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

    // Instruction memory, random delay of 1 to 4 cycles per request
    always @(posedge clk) begin
        if (rst) begin
            imem_resp   <= 1'b0;
            mem_pending = 1'b0;
            fetch_addr  = '0;
        end else if (imem_resp) begin
            // Read still looks high on this edge
            imem_resp <= 1'b0;
        end else if (imem_read || mem_pending) begin
            // Request level and address hold until the response
            check_value("imem_read", {31'b0, imem_read}, 32'd1);
            check_value("imem_addr", imem_addr, fetch_addr);
            if (!mem_pending) begin
                mem_pending = 1'b1;
                wait_left   = int'($urandom_range(1, 4));
            end
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                mem_pending = 1'b0;
                imem_resp  <= 1'b1;
                imem_rdata <= fetch_word(imem_addr);
                fetch_addr  = fetch_addr + 32'd4;
            end
        end
    end

    // Commit checker, in program order
    always @(posedge clk) begin : commit_check
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        if (!rst && commit_valid) begin
            ref_step(prog_mem[committed], exp_rd, exp_data);
            check_value("commit_pc", commit_pc, 32'(committed * 4));
            check_value("commit_rd", 32'(commit_rd), 32'(exp_rd));
            check_value("commit_data", commit_data, exp_data);
            committed = committed + 1;
            if (committed == NUM_INSTR) begin
                $display("SIMULATION PASSED");
                $finish;
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        if (rst) begin
            cycles = 0;
        end else begin
            cycles = cycles + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d of %0d instructions committed",
                     cycles, committed, NUM_INSTR);
            $display("SIMULATION FAILED");
            $fatal(1, "Core stopped committing");
        end
    end

endmodule
